//--- flist.f
rtl/soc_bus_pkg.sv
rtl/soc_map_pkg.sv
rtl/bus_decoder.sv
rtl/data_memory.sv
rtl/gpio_port.sv
rtl/interval_timer.sv
rtl/interrupt_controller.sv
rtl/peripheral_system.sv
verification/peripheral_system_assertions.sv
verification/peripheral_system_tb.sv

//--- rtl/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
#(
    parameter int MEMORY_BYTES = 4096
) (
    input  logic           clk_i,
    input  logic           rst_n_i,

    input  bus_request_t   bus_request_i,
    output bus_response_t  bus_response_o,

    output slave_request_t mem_req_o,
    output slave_request_t gpio_req_o,
    output slave_request_t timer_req_o,

    input  word_t          mem_rdata_i,
    input  word_t          gpio_rdata_i,
    input  word_t          timer_rdata_i,

    output logic           bus_error_o
);

    // ====================
    // Decode
    // ====================

    addr_t         address;
    addr_t         mem_offset;
    access_width_t width;
    device_sel_t   sel;
    logic          misaligned;
    logic          error;
    logic          access;
    strobe_t       strobe;
    word_t         lane_data;

    assign address    = bus_request_i.address;
    assign width      = bus_request_i.width;
    assign mem_offset = address - memory_base;
    assign access     = bus_request_i.store | bus_request_i.load;

    always_comb begin
        if (mem_offset < addr_t'(MEMORY_BYTES)) begin
            sel = DEV_MEMORY;
        end else if (address[31:peripheral_window_bits] ==
                     gpio_base[31:peripheral_window_bits]) begin
            sel = DEV_GPIO;
        end else if (address[31:peripheral_window_bits] ==
                     timer_base[31:peripheral_window_bits]) begin
            sel = DEV_TIMER;
        end else begin
            sel = DEV_NONE;
        end
    end

    assign misaligned = ((width == HALF_WORD) && address[0]) ||
                        ((width == WORD) && (address[1:0] != 2'b00));

    // Peripherals only take full words
    assign error = (sel == DEV_NONE) || misaligned ||
                   ((sel != DEV_MEMORY) && (width != WORD));

    always_comb begin
        case (width)
            WORD:      strobe = 4'b1111;
            HALF_WORD: strobe = 4'b0011 << {address[1], 1'b0};
            BYTE:      strobe = 4'b0001 << address[1:0];
            default:   strobe = 4'b0000;
        endcase
    end

    // Move low lane data up to the addressed byte
    assign lane_data = bus_request_i.data << {address[1:0], 3'b000};

    always_comb begin
        mem_req_o   = '{write: 1'b0, read: 1'b0, index: mem_offset >> 2,
                        data: lane_data, strobe: strobe};
        gpio_req_o  = '{write: 1'b0, read: 1'b0, index: address >> 2,
                        data: lane_data, strobe: strobe};
        timer_req_o = gpio_req_o;

        if (!error) begin
            case (sel)
                DEV_MEMORY: begin
                    mem_req_o.write = bus_request_i.store;
                    mem_req_o.read  = bus_request_i.load;
                end
                DEV_GPIO: begin
                    gpio_req_o.write = bus_request_i.store;
                    gpio_req_o.read  = bus_request_i.load;
                end
                DEV_TIMER: begin
                    timer_req_o.write = bus_request_i.store;
                    timer_req_o.read  = bus_request_i.load;
                end
                default: ;
            endcase
        end
    end

    // ====================
    // Response
    // ====================

    device_sel_t sel_q;
    logic        error_q;
    logic        done_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sel_q   <= DEV_NONE;
            error_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= access;
            if (access) begin
                sel_q   <= sel;
                error_q <= error;
            end
        end
    end

    always_comb begin
        bus_response_o.done  = done_q;
        bus_response_o.error = done_q & error_q;
        if (error_q) begin
            bus_response_o.rdata = '0;
        end else begin
            case (sel_q)
                DEV_MEMORY: bus_response_o.rdata = mem_rdata_i;
                DEV_GPIO:   bus_response_o.rdata = gpio_rdata_i;
                DEV_TIMER:  bus_response_o.rdata = timer_rdata_i;
                default:    bus_response_o.rdata = '0;
            endcase
        end
    end

    // Interrupt source pulse lines up with the error response
    assign bus_error_o = done_q & error_q;

endmodule : bus_decoder

//--- rtl/data_memory.sv
`timescale 1ns/1ps

module data_memory
    import soc_bus_pkg::*;
#(
    parameter int MEMORY_BYTES = 4096
) (
    input  logic           clk_i,
    input  slave_request_t mem_req_i,
    output word_t          rdata_o
);

    localparam int WORDS      = MEMORY_BYTES / 4;
    localparam int INDEX_BITS = $clog2(WORDS);

    word_t                 mem [WORDS];
    logic [INDEX_BITS-1:0] word_index;

    // Decoder guarantees the index is inside the array
    assign word_index = mem_req_i.index[INDEX_BITS-1:0];

    always_ff @(posedge clk_i) begin
        if (mem_req_i.write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (mem_req_i.strobe[lane]) begin
                    mem[word_index][lane*8 +: 8] <= mem_req_i.data[lane*8 +: 8];
                end
            end
        end
    end

    // Registered read port
    always_ff @(posedge clk_i) begin
        if (mem_req_i.read) begin
            rdata_o <= mem[word_index];
        end
    end

endmodule : data_memory

//--- rtl/gpio_port.sv
`timescale 1ns/1ps

module gpio_port
    import soc_bus_pkg::*;
#(
    parameter int GPIO_PINS = 8
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  slave_request_t       gpio_req_i,
    output word_t                rdata_o,

    input  logic [GPIO_PINS-1:0] gpio_in_i,
    output logic [GPIO_PINS-1:0] gpio_out_o,
    output logic [GPIO_PINS-1:0] gpio_oe_o,

    output logic                 irq_o
);

    reg_index_t           reg_index;
    logic [GPIO_PINS-1:0] out_q;
    logic [GPIO_PINS-1:0] dir_q;
    logic [GPIO_PINS-1:0] mask_q;
    logic [GPIO_PINS-1:0] in_meta_q;
    logic [GPIO_PINS-1:0] in_q;
    logic [GPIO_PINS-1:0] in_prev_q;
    logic                 irq_q;

    assign reg_index = gpio_req_i.index[3:0];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q     <= '0;
            dir_q     <= '0;
            mask_q    <= '0;
            in_meta_q <= '0;
            in_q      <= '0;
            in_prev_q <= '0;
            irq_q     <= 1'b0;
        end else begin
            // Two flop input sync, then edge detect on the clean copy
            in_meta_q <= gpio_in_i;
            in_q      <= in_meta_q;
            in_prev_q <= in_q;
            irq_q     <= |(in_q & ~in_prev_q & mask_q);

            if (gpio_req_i.write) begin
                case (reg_index)
                    4'd0: out_q  <= gpio_req_i.data[GPIO_PINS-1:0];
                    4'd1: dir_q  <= gpio_req_i.data[GPIO_PINS-1:0];
                    4'd3: mask_q <= gpio_req_i.data[GPIO_PINS-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (gpio_req_i.read) begin
            case (reg_index)
                4'd0:    rdata_o <= word_t'(out_q);
                4'd1:    rdata_o <= word_t'(dir_q);
                4'd2:    rdata_o <= word_t'(in_q);
                4'd3:    rdata_o <= word_t'(mask_q);
                default: rdata_o <= '0;
            endcase
        end
    end

    assign gpio_out_o = out_q;
    assign gpio_oe_o  = dir_q;
    assign irq_o      = irq_q;

endmodule : gpio_port

//--- rtl/interrupt_controller.sv
`timescale 1ns/1ps

module interrupt_controller
    import soc_map_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  irq_source_t irq_source_i,
    input  logic        ack_i,
    output logic        irq_o,
    output irq_vector_t vector_o
);

    irq_source_t pending_q;
    irq_source_t clear;

    assign irq_o = |pending_q;

    // Lowest pending source has priority
    always_comb begin
        vector_o = '0;
        for (int i = $bits(irq_source_t) - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                vector_o = irq_vector_t'(i);
            end
        end
    end

    always_comb begin
        clear = '0;
        if (ack_i && irq_o) begin
            clear[vector_o] = 1'b1;
        end
    end

    // New pulse in the clear cycle keeps its bit set
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~clear) | irq_source_i;
        end
    end

endmodule : interrupt_controller

//--- rtl/interval_timer.sv
`timescale 1ns/1ps

module interval_timer
    import soc_bus_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  slave_request_t timer_req_i,
    output word_t          rdata_o,
    output logic           irq_o
);

    reg_index_t reg_index;
    word_t      count_q;
    word_t      compare_q;
    logic       enable_q;
    logic       irq_q;
    logic       match;

    assign reg_index = timer_req_i.index[3:0];
    assign match     = enable_q && (count_q == compare_q);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q   <= '0;
            compare_q <= '0;
            enable_q  <= 1'b0;
            irq_q     <= 1'b0;
        end else begin
            irq_q <= match;

            // A counter write takes priority over counting
            if (timer_req_i.write && (reg_index == 4'd0)) begin
                count_q <= timer_req_i.data;
            end else if (match) begin
                count_q <= '0;
            end else if (enable_q) begin
                count_q <= count_q + 1'b1;
            end

            if (timer_req_i.write && (reg_index == 4'd1)) begin
                compare_q <= timer_req_i.data;
            end
            if (timer_req_i.write && (reg_index == 4'd2)) begin
                enable_q <= timer_req_i.data[0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (timer_req_i.read) begin
            case (reg_index)
                4'd0:    rdata_o <= count_q;
                4'd1:    rdata_o <= compare_q;
                4'd2:    rdata_o <= word_t'(enable_q);
                default: rdata_o <= '0;
            endcase
        end
    end

    assign irq_o = irq_q;

endmodule : interval_timer

//--- rtl/peripheral_system.sv
`timescale 1ns/1ps

module peripheral_system
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
#(
    parameter int MEMORY_BYTES = 4096,
    parameter int GPIO_PINS    = 8
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  bus_request_t         bus_request_i,
    output bus_response_t        bus_response_o,

    input  logic [GPIO_PINS-1:0] gpio_in_i,
    output logic [GPIO_PINS-1:0] gpio_out_o,
    output logic [GPIO_PINS-1:0] gpio_oe_o,

    output logic                 irq_o,
    output irq_vector_t          irq_vector_o,
    input  logic                 irq_ack_i
);

    // ====================
    // Reset synchronizer
    // ====================

    logic rst_sync_q;
    logic reset_n;

    // Asserts at once, releases two edges after rst_n_i rises
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rst_sync_q <= 1'b0;
            reset_n    <= 1'b0;
        end else begin
            rst_sync_q <= 1'b1;
            reset_n    <= rst_sync_q;
        end
    end

    // ====================
    // Bus and devices
    // ====================

    slave_request_t mem_req;
    slave_request_t gpio_req;
    slave_request_t timer_req;

    word_t mem_rdata;
    word_t gpio_rdata;
    word_t timer_rdata;

    irq_source_t irq_source;

    bus_decoder #(
        .MEMORY_BYTES (MEMORY_BYTES)
    ) u_decoder (
        .clk_i          (clk_i),
        .rst_n_i        (reset_n),
        .bus_request_i  (bus_request_i),
        .bus_response_o (bus_response_o),
        .mem_req_o      (mem_req),
        .gpio_req_o     (gpio_req),
        .timer_req_o    (timer_req),
        .mem_rdata_i    (mem_rdata),
        .gpio_rdata_i   (gpio_rdata),
        .timer_rdata_i  (timer_rdata),
        .bus_error_o    (irq_source[2])
    );

    data_memory #(
        .MEMORY_BYTES (MEMORY_BYTES)
    ) u_memory (
        .clk_i     (clk_i),
        .mem_req_i (mem_req),
        .rdata_o   (mem_rdata)
    );

    gpio_port #(
        .GPIO_PINS (GPIO_PINS)
    ) u_gpio (
        .clk_i      (clk_i),
        .rst_n_i    (reset_n),
        .gpio_req_i (gpio_req),
        .rdata_o    (gpio_rdata),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o),
        .gpio_oe_o  (gpio_oe_o),
        .irq_o      (irq_source[0])
    );

    interval_timer u_timer (
        .clk_i       (clk_i),
        .rst_n_i     (reset_n),
        .timer_req_i (timer_req),
        .rdata_o     (timer_rdata),
        .irq_o       (irq_source[1])
    );

    interrupt_controller u_intc (
        .clk_i        (clk_i),
        .rst_n_i      (reset_n),
        .irq_source_i (irq_source),
        .ack_i        (irq_ack_i),
        .irq_o        (irq_o),
        .vector_o     (irq_vector_o)
    );

endmodule : peripheral_system

//--- rtl/soc_bus_pkg.sv
package soc_bus_pkg;

    // Basic bus widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strobe_t;

    // Register slot inside a peripheral, address bits 5 to 2
    typedef logic [3:0]  reg_index_t;

    typedef enum logic [1:0] {
        BYTE,
        HALF_WORD,
        WORD
    } access_width_t;

    // Master side request, data sits in the low lanes
    typedef struct packed {
        logic          store;
        logic          load;
        addr_t         address;
        access_width_t width;
        word_t         data;
    } bus_request_t;

    typedef struct packed {
        logic  done;
        logic  error;
        word_t rdata;
    } bus_response_t;

    // Per device request, index is a word index (low bits select a register)
    typedef struct packed {
        logic    write;
        logic    read;
        addr_t   index;
        word_t   data;
        strobe_t strobe;
    } slave_request_t;

endpackage : soc_bus_pkg

//--- rtl/soc_map_pkg.sv
package soc_map_pkg;

    import soc_bus_pkg::*;

    // Device windows
    parameter addr_t memory_base = 32'h0000_0000;
    parameter addr_t gpio_base   = 32'h0001_0000;
    parameter addr_t timer_base  = 32'h0001_0080;

    // Peripheral windows are 64 bytes, so the window check uses bits 31 to 6
    parameter int peripheral_window_bits = 6;

    typedef enum logic [1:0] {
        DEV_MEMORY,
        DEV_GPIO,
        DEV_TIMER,
        DEV_NONE
    } device_sel_t;

    // Bit 0 GPIO, bit 1 timer, bit 2 bus error
    typedef logic [2:0] irq_source_t;

    typedef logic [1:0] irq_vector_t;

endpackage : soc_map_pkg

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the peripheral_system testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_peripheral_system
LOG_FILE=sim.log
FAIL_TEXT="Simulation finished: FAIL"

verilator --binary --timing --assert -Wno-fatal \
    --top-module peripheral_system_tb \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
    -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "$FAIL_TEXT" "$LOG_FILE"; then
    echo "Testbench reported a failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

echo "Run completed without failure"
exit 0

//--- verification/peripheral_system_assertions.sv
`timescale 1ns/1ps

module peripheral_system_assertions
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
#(
    parameter int GPIO_PINS = 8
) (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 reset_n_i,
    input bus_request_t         bus_request_i,
    input bus_response_t        bus_response_i,
    input logic [GPIO_PINS-1:0] gpio_out_i,
    input logic [GPIO_PINS-1:0] gpio_oe_i,
    input logic                 irq_i,
    input irq_source_t          irq_source_i
);

    logic access;

    assign access = bus_request_i.store | bus_request_i.load;

    // Fixed one cycle response latency
    request_gets_done: assert property (
        @(posedge clk_i) disable iff (!reset_n_i) access |=> bus_response_i.done
    ) else $error("Bus request was not answered with done one cycle later");

    done_single_cycle: assert property (
        @(posedge clk_i) disable iff (!reset_n_i) bus_response_i.done |=> !bus_response_i.done
    ) else $error("Done stayed high for two cycles");

    // Nothing becomes pending without a source pulse
    irq_needs_source: assert property (
        @(posedge clk_i) disable iff (!reset_n_i)
            (!irq_i && irq_source_i == '0) |=> !irq_i
    ) else $error("Interrupt line rose with nothing pending");

    quiet_in_reset: assert property (
        @(posedge clk_i) !rst_n_i |-> (!bus_response_i.done && !irq_i &&
                                        gpio_out_i == '0 && gpio_oe_i == '0)
    ) else $error("Outputs active while reset is asserted");

endmodule : peripheral_system_assertions

bind peripheral_system peripheral_system_assertions #(
    .GPIO_PINS (GPIO_PINS)
) u_assertions (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .reset_n_i      (reset_n),
    .bus_request_i  (bus_request_i),
    .bus_response_i (bus_response_o),
    .gpio_out_i     (gpio_out_o),
    .gpio_oe_i      (gpio_oe_o),
    .irq_i          (irq_o),
    .irq_source_i   (irq_source)
);

//--- verification/peripheral_system_tb.sv
`timescale 1ns/1ps

module peripheral_system_tb
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
();

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 10;
    localparam int MEMORY_BYTES    = 4096;
    localparam int GPIO_PINS       = 8;
    localparam int TEST_BYTES      = 256;
    localparam int RANDOM_OPS      = 300;
    localparam int DONE_LIMIT      = 4;
    localparam int OP_BOUND_CYCLES = 40;
    localparam int TOTAL_OPS       = 2 * (TEST_BYTES / 4) + RANDOM_OPS + 80;
    localparam int WATCHDOG_NS     = (RESET_CYCLES + 2 + TOTAL_OPS * OP_BOUND_CYCLES) * CLK_PERIOD;

    // Register addresses
    localparam addr_t GPIO_OUT      = gpio_base;
    localparam addr_t GPIO_DIR      = gpio_base + 32'h4;
    localparam addr_t GPIO_IN       = gpio_base + 32'h8;
    localparam addr_t GPIO_MASK     = gpio_base + 32'hC;
    localparam addr_t TIMER_COUNT   = timer_base;
    localparam addr_t TIMER_COMPARE = timer_base + 32'h4;
    localparam addr_t TIMER_CONTROL = timer_base + 32'h8;

    logic                 clk;
    logic                 rst_n;
    bus_request_t         bus_request;
    bus_response_t        bus_response;
    logic [GPIO_PINS-1:0] gpio_in;
    logic [GPIO_PINS-1:0] gpio_out;
    logic [GPIO_PINS-1:0] gpio_oe;
    logic                 irq;
    irq_vector_t          irq_vector;
    logic                 irq_ack;

    // Byte model of the tested memory window
    logic [7:0] mem_model [TEST_BYTES];
    int         error_count;

    peripheral_system #(
        .MEMORY_BYTES (MEMORY_BYTES),
        .GPIO_PINS    (GPIO_PINS)
    ) uut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .bus_request_i  (bus_request),
        .bus_response_o (bus_response),
        .gpio_in_i      (gpio_in),
        .gpio_out_o     (gpio_out),
        .gpio_oe_o      (gpio_oe),
        .irq_o          (irq),
        .irq_vector_o   (irq_vector),
        .irq_ack_i      (irq_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // Helpers
    // ====================

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            error_count++;
            abort_run($sformatf("Error at time %0t: %s, got 0x%08h, expected 0x%08h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic settle(input int cycles);
        repeat (cycles) @(posedge clk);
        #1;
    endtask

    // One request, then poll for done
    task automatic bus_access(input logic is_store, input addr_t addr,
                              input access_width_t acc_width, input word_t wdata,
                              output word_t rdata, output logic error);
        int waited;
        @(posedge clk);
        #1;
        bus_request = '{store: is_store, load: !is_store, address: addr,
                        width: acc_width, data: wdata};
        @(posedge clk);
        #1;
        bus_request = '0;
        waited = 1;
        while (bus_response.done !== 1'b1) begin
            if (waited >= DONE_LIMIT) begin
                abort_run($sformatf("No done response for the access at 0x%08h", addr));
            end
            @(posedge clk);
            #1;
            waited++;
        end
        rdata = bus_response.rdata;
        error = bus_response.error;
    endtask

    task automatic write_register(input addr_t addr, input word_t data);
        word_t rdata;
        logic  err;
        bus_access(1'b1, addr, WORD, data, rdata, err);
        check_value(word_t'(err), '0, $sformatf("store error flag at 0x%08h", addr));
    endtask

    task automatic read_register(input addr_t addr, output word_t data);
        logic err;
        bus_access(1'b0, addr, WORD, '0, data, err);
        check_value(word_t'(err), '0, $sformatf("load error flag at 0x%08h", addr));
    endtask

    // Multiplier is odd, so every address bit reaches the pattern
    function automatic word_t fill_pattern(input addr_t addr);
        return (addr * 32'h0100_0193) ^ 32'h811C_9DC5;
    endfunction

    function automatic word_t expected_word(input addr_t addr);
        int a;
        a = int'(addr);
        return {mem_model[a + 3], mem_model[a + 2], mem_model[a + 1], mem_model[a]};
    endfunction

    // Low data bytes land at addr, addr+1, ...
    task automatic memory_store(input addr_t addr, input access_width_t acc_width,
                                input word_t data);
        word_t rdata;
        logic  err;
        int    lanes;
        lanes = (acc_width == WORD) ? 4 : ((acc_width == HALF_WORD) ? 2 : 1);
        bus_access(1'b1, addr, acc_width, data, rdata, err);
        check_value(word_t'(err), '0, $sformatf("memory store error flag at 0x%08h", addr));
        for (int b = 0; b < lanes; b++) begin
            mem_model[int'(addr) + b] = data[8*b +: 8];
        end
    endtask

    task automatic memory_load_check(input addr_t addr);
        word_t rdata;
        read_register(addr, rdata);
        check_value(rdata, expected_word(addr), $sformatf("memory word at 0x%08h", addr));
    endtask

    task automatic acknowledge_irq();
        @(posedge clk);
        #1;
        irq_ack = 1'b1;
        @(posedge clk);
        #1;
        irq_ack = 1'b0;
    endtask

    task automatic wait_for_vector(input irq_vector_t vector, input int limit,
                                   input string what);
        int waited;
        waited = 0;
        while (!(irq === 1'b1 && irq_vector === vector)) begin
            if (waited >= limit) begin
                abort_run($sformatf("The %s never showed up on vector %0d", what, vector));
            end
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    task automatic expect_bus_error(input logic is_store, input addr_t addr,
                                    input access_width_t acc_width, input string what);
        word_t rdata;
        logic  err;
        bus_access(is_store, addr, acc_width, $urandom, rdata, err);
        check_value(word_t'(err), 32'd1, {what, " error flag"});
        check_value(rdata, '0, {what, " read data"});
        // Pending bit lands one edge after the error response
        @(posedge clk);
        #1;
        check_value(word_t'(irq), 32'd1, {what, " interrupt"});
        check_value(word_t'(irq_vector), 32'd2, {what, " vector"});
        acknowledge_irq();
        check_value(word_t'(irq), '0, {what, " interrupt after acknowledge"});
    endtask

    // ====================
    // Test sequence
    // ====================

    initial begin : main_sequence
        word_t                rdata;
        addr_t                addr;
        access_width_t        acc_width;
        logic [GPIO_PINS-1:0] pins;
        int                   pin_masked;
        int                   pin_other;
        int                   compare;

        void'($urandom(69));
        clk         = 1'b0;
        rst_n       = 1'b1;
        bus_request = '0;
        gpio_in     = '0;
        irq_ack     = 1'b0;
        error_count = 0;

        #2 rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        settle(2);

        // Known contents for the whole window first
        for (int a = 0; a < TEST_BYTES; a += 4) begin
            memory_store(addr_t'(a), WORD, fill_pattern(addr_t'(a)));
        end

        for (int op = 0; op < RANDOM_OPS; op++) begin
            addr = addr_t'($urandom_range(0, TEST_BYTES - 1));
            if ($urandom_range(0, 2) == 0) begin
                memory_load_check(addr & ~addr_t'(3));
            end else begin
                acc_width = access_width_t'($urandom_range(0, 2));
                if (acc_width == HALF_WORD) begin
                    addr[0] = 1'b0;
                end else if (acc_width == WORD) begin
                    addr[1:0] = 2'b00;
                end
                memory_store(addr, acc_width, $urandom);
            end
        end

        for (int a = 0; a < TEST_BYTES; a += 4) begin
            memory_load_check(addr_t'(a));
        end

        // Bus errors, memory must stay as it was
        expect_bus_error(1'b1, 32'h0000_0001, HALF_WORD, "misaligned half-word store");
        expect_bus_error(1'b1, 32'h0000_0006, WORD, "misaligned word store");
        expect_bus_error(1'b0, 32'h0000_0003, WORD, "misaligned word load");
        expect_bus_error(1'b0, addr_t'(MEMORY_BYTES), WORD, "load past memory");
        expect_bus_error(1'b1, gpio_base + 32'h40, WORD, "store between windows");
        expect_bus_error(1'b0, GPIO_OUT, BYTE, "byte load from GPIO");
        expect_bus_error(1'b1, TIMER_COMPARE, HALF_WORD, "half-word store to timer");
        memory_load_check(32'h0000_0000);
        memory_load_check(32'h0000_0004);

        // GPIO outputs, direction and input readback
        for (int i = 0; i < 4; i++) begin
            pins = GPIO_PINS'($urandom);
            write_register(GPIO_OUT, word_t'(pins));
            check_value(word_t'(gpio_out), word_t'(pins), "gpio_out_o after write");
            read_register(GPIO_OUT, rdata);
            check_value(rdata, word_t'(pins), "GPIO output register");
            pins = GPIO_PINS'($urandom);
            write_register(GPIO_DIR, word_t'(pins));
            check_value(word_t'(gpio_oe), word_t'(pins), "gpio_oe_o after write");
            gpio_in = GPIO_PINS'($urandom);
            settle(4);
            read_register(GPIO_IN, rdata);
            check_value(rdata, word_t'(gpio_in), "GPIO input register");
        end

        // Edge interrupt only on the masked pin
        pin_masked = $urandom_range(0, GPIO_PINS - 1);
        pin_other  = (pin_masked + $urandom_range(1, GPIO_PINS - 1)) % GPIO_PINS;
        gpio_in    = '0;
        settle(4);
        write_register(GPIO_MASK, word_t'(1) << pin_masked);
        gpio_in[pin_other] = 1'b1;
        settle(6);
        check_value(word_t'(irq), '0, "interrupt from an unmasked pin");
        gpio_in[pin_masked] = 1'b1;
        wait_for_vector(2'd0, 8, "GPIO edge interrupt");
        acknowledge_irq();
        check_value(word_t'(irq), '0, "interrupt after GPIO acknowledge");

        // Timer alone
        compare = $urandom_range(4, 20);
        write_register(TIMER_COMPARE, word_t'(compare));
        write_register(TIMER_COUNT, '0);
        write_register(TIMER_CONTROL, 32'd1);
        wait_for_vector(2'd1, compare + 6, "timer compare interrupt");
        write_register(TIMER_CONTROL, '0);
        settle(2);
        acknowledge_irq();
        check_value(word_t'(irq), '0, "interrupt after timer acknowledge");

        // Timer and GPIO pending together, GPIO wins first
        write_register(TIMER_COUNT, '0);
        write_register(TIMER_CONTROL, 32'd1);
        wait_for_vector(2'd1, compare + 6, "second timer interrupt");
        write_register(TIMER_CONTROL, '0);
        gpio_in[pin_masked] = 1'b0;
        settle(4);
        gpio_in[pin_masked] = 1'b1;
        wait_for_vector(2'd0, 8, "GPIO interrupt over a pending timer");
        acknowledge_irq();
        check_value(word_t'(irq), 32'd1, "interrupt with timer still pending");
        check_value(word_t'(irq_vector), 32'd1, "vector after GPIO acknowledge");
        acknowledge_irq();
        check_value(word_t'(irq), '0, "interrupt after both acknowledged");

        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run("Watchdog expired before the test sequence completed");
    end

endmodule : peripheral_system_tb
